// File: common/wb_params.svh
// shared sizes of the write-back back end, included by any file that sizes a bus or memory
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// data path width
`define WB_XLEN 64

// program counter width
`define WB_PC_W 64

// general register index, 32 registers
`define WB_REG_IDX_W 5

// data RAM of 64-bit words
`define WB_MEM_DEPTH 256
`define WB_MEM_IDX_W 8

`endif

// File: common/wb_pkg.sv
// types shared by the back-end stages, imported by every module that builds or reads a bundle
`default_nettype none

`include "wb_params.svh"

package wb_pkg;

    // memory operation carried down from decode
    typedef enum logic [3:0] {
        NONE, LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD
    } mem_op_e;

    typedef struct packed {
        logic                     valid;
        logic [`WB_PC_W-1:0]      pc;
        mem_op_e                  op;
        logic [`WB_XLEN-1:0]      addr;
        // store data, or the ALU result for op NONE
        logic [`WB_XLEN-1:0]      wdata;
        logic [`WB_REG_IDX_W-1:0] rd_addr;
        logic                     rd_en;
    } ex_mem_t;

    typedef struct packed {
        logic                     valid;
        logic [`WB_PC_W-1:0]      pc;
        logic [`WB_REG_IDX_W-1:0] rd_addr;
        logic                     rd_en;
        logic [`WB_XLEN-1:0]      rd_data;
    } mem_wb_t;

    // hold_wb is the top bit, hold_if bit 0
    typedef struct packed {
        logic hold_wb;
        logic hold_mem;
        logic hold_ex;
        logic hold_id;
        logic hold_if;
    } stall_vec_t;

    typedef struct packed {
        logic                     valid;
        logic [`WB_PC_W-1:0]      pc;
        logic [`WB_REG_IDX_W-1:0] rd_addr;
        logic                     rd_en;
        logic [`WB_XLEN-1:0]      rd_data;
    } commit_t;

    // one RAM word seen as byte, half or word lanes
    typedef union packed {
        logic [`WB_XLEN/8-1:0][7:0]   b;
        logic [`WB_XLEN/16-1:0][15:0] h;
        logic [`WB_XLEN/32-1:0][31:0] w;
    } mem_word_u;

endpackage

`default_nettype wire

// File: mem_stage/mem_access.sv
// memory stage: data RAM with load lane extraction and store byte merging, feeds MEM/WB
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module mem_access (
    input  logic            clk,
    input  wb_pkg::ex_mem_t ex_mem_i,
    input  logic            hold_mem_i,
    output wb_pkg::mem_wb_t mem_res_o
);
    import wb_pkg::*;

    mem_word_u                ram [`WB_MEM_DEPTH];
    mem_word_u                rd_word;
    mem_word_u                wr_word;
    logic [`WB_MEM_IDX_W-1:0] idx;
    logic [2:0]               boff;
    logic [1:0]               hoff;
    logic                     woff;
    logic                     is_store;
    logic                     ram_we;
    logic [`WB_XLEN-1:0]      res_data;

    // low three bits pick the lane, access is aligned down to its size
    assign idx  = ex_mem_i.addr[`WB_MEM_IDX_W+2:3];
    assign boff = ex_mem_i.addr[2:0];
    assign hoff = ex_mem_i.addr[2:1];
    assign woff = ex_mem_i.addr[2];

    assign rd_word  = ram[idx];
    assign is_store = ex_mem_i.op inside {SB, SH, SW, SD};
    assign ram_we   = ex_mem_i.valid && is_store && !hold_mem_i;

    // result mux, loads extended to full width
    always_comb begin
        unique case (ex_mem_i.op)
            NONE: res_data = ex_mem_i.wdata;
            LB:   res_data = {{(`WB_XLEN-8){rd_word.b[boff][7]}}, rd_word.b[boff]};
            LH:   res_data = {{(`WB_XLEN-16){rd_word.h[hoff][15]}}, rd_word.h[hoff]};
            LW:   res_data = {{(`WB_XLEN-32){rd_word.w[woff][31]}}, rd_word.w[woff]};
            LD:   res_data = rd_word;
            LBU:  res_data = {{(`WB_XLEN-8){1'b0}}, rd_word.b[boff]};
            LHU:  res_data = {{(`WB_XLEN-16){1'b0}}, rd_word.h[hoff]};
            LWU:  res_data = {{(`WB_XLEN-32){1'b0}}, rd_word.w[woff]};
            default: res_data = '0;
        endcase
    end

    // read-modify-write of the addressed word
    always_comb begin
        wr_word = rd_word;
        unique case (ex_mem_i.op)
            SB: wr_word.b[boff] = ex_mem_i.wdata[7:0];
            SH: wr_word.h[hoff] = ex_mem_i.wdata[15:0];
            SW: wr_word.w[woff] = ex_mem_i.wdata[31:0];
            SD: wr_word = ex_mem_i.wdata;
            default: wr_word = rd_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[idx] <= wr_word;
        end
    end

    assign mem_res_o.valid   = ex_mem_i.valid;
    assign mem_res_o.pc      = ex_mem_i.pc;
    assign mem_res_o.rd_addr = ex_mem_i.rd_addr;
    // stores never write a register
    assign mem_res_o.rd_en   = ex_mem_i.rd_en && !is_store;
    assign mem_res_o.rd_data = res_data;

endmodule

`default_nettype wire

// File: src/stall_ctrl.sv
// stall controller: turns level stall requests into the per-stage hold vector for the pipeline
`timescale 1ns/1ps
`default_nettype none

module stall_ctrl (
    input  logic               mem_stall_req_i,
    input  logic               wb_stall_req_i,
    output wb_pkg::stall_vec_t stall_o
);

    // a hold in one stage also holds every stage before it
    always_comb begin
        stall_o.hold_wb  = wb_stall_req_i;
        stall_o.hold_mem = stall_o.hold_wb || mem_stall_req_i;
        stall_o.hold_ex  = stall_o.hold_mem;
        stall_o.hold_id  = stall_o.hold_ex;
        stall_o.hold_if  = stall_o.hold_id;
    end

endmodule

`default_nettype wire

// File: src/mem_wb_reg.sv
// MEM/WB pipeline register with hold and bubble control, and the one-shot commit record
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  logic               clk,
    input  logic               arst_n_i,
    input  wb_pkg::mem_wb_t    mem_res_i,
    input  wb_pkg::stall_vec_t stall_i,
    output wb_pkg::mem_wb_t    wb_o,
    output wb_pkg::commit_t    commit_o
);
    import wb_pkg::*;

    mem_wb_t wb_q;
    logic    commit_q;

    // hold beats bubble, bubble beats load
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_q <= '0;
        end else if (stall_i.hold_wb) begin
            wb_q <= wb_q;
        end else if (stall_i.hold_mem) begin
            wb_q <= '0;
        end else begin
            wb_q <= mem_res_i;
        end
    end

    // set only on the edge that loads a valid bundle, so a held entry retires once
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_q <= 1'b0;
        end else begin
            commit_q <= !stall_i.hold_wb && !stall_i.hold_mem && mem_res_i.valid;
        end
    end

    assign wb_o = wb_q;

    assign commit_o.valid   = commit_q;
    assign commit_o.pc      = wb_q.pc;
    assign commit_o.rd_addr = wb_q.rd_addr;
    assign commit_o.rd_en   = wb_q.rd_en;
    assign commit_o.rd_data = wb_q.rd_data;

endmodule

`default_nettype wire

// File: src/gpr_file.sv
// general register file, written from the write-back bundle, with a debug read port
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module gpr_file (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  wb_pkg::mem_wb_t          wb_i,
    input  logic [`WB_REG_IDX_W-1:0] dbg_raddr_i,
    output logic [`WB_XLEN-1:0]      dbg_rdata_o
);

    logic [`WB_XLEN-1:0] regs [1 << `WB_REG_IDX_W];
    logic                we;

    assign we = wb_i.valid && wb_i.rd_en && (wb_i.rd_addr != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < (1 << `WB_REG_IDX_W); i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb_i.rd_addr] <= wb_i.rd_data;
        end
    end

    // x0 is never written so it keeps its reset value of zero
    assign dbg_rdata_o = regs[dbg_raddr_i];

endmodule

`default_nettype wire

// File: src/wb_backend_top.sv
// back-end top: memory stage, stall control, MEM/WB register and register file wired together
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module wb_backend_top (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  wb_pkg::ex_mem_t          ex_mem_i,
    input  logic                     mem_stall_req_i,
    input  logic                     wb_stall_req_i,
    input  logic [`WB_REG_IDX_W-1:0] dbg_raddr_i,
    output wb_pkg::stall_vec_t       stall_o,
    output wb_pkg::commit_t          commit_o,
    output logic [`WB_XLEN-1:0]      dbg_rdata_o
);
    import wb_pkg::*;

    mem_wb_t    mem_res;
    mem_wb_t    wb;
    stall_vec_t stall;

    mem_access u_mem_access (
        .clk        (clk),
        .ex_mem_i   (ex_mem_i),
        .hold_mem_i (stall.hold_mem),
        .mem_res_o  (mem_res)
    );

    stall_ctrl u_stall_ctrl (
        .mem_stall_req_i (mem_stall_req_i),
        .wb_stall_req_i  (wb_stall_req_i),
        .stall_o         (stall)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .mem_res_i (mem_res),
        .stall_i   (stall),
        .wb_o      (wb),
        .commit_o  (commit_o)
    );

    gpr_file u_gpr_file (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .wb_i        (wb),
        .dbg_raddr_i (dbg_raddr_i),
        .dbg_rdata_o (dbg_rdata_o)
    );

    // upstream stages see the same hold vector
    assign stall_o = stall;

endmodule

`default_nettype wire

// File: test/tb_clock.sv
// testbench clock and power-on reset source, instantiated once by the back-end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // held low for the first four rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: test/wb_backend_tb.sv
// testbench for the write-back back end, replays test/wb_cases.txt step by step against the DUT
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module wb_backend_tb;
    import wb_pkg::*;

    // one line of the cases file with commit fields expected one cycle later
    typedef struct packed {
        logic [3:0]  test;
        logic        rst;
        logic        valid;
        logic [31:0] pc_lo;
        logic [3:0]  op;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [4:0]  rd;
        logic        rd_en;
        logic        mreq;
        logic        wreq;
        logic [4:0]  dbg;
        logic        c_valid;
        logic [4:0]  c_rd;
        logic        c_rd_en;
        logic [63:0] c_data;
        logic [4:0]  stall;
        logic [63:0] dbg_data;
    } step_t;

    logic                     clk;
    logic                     rst_n;
    logic                     rst_req;
    logic                     arst_n;
    ex_mem_t                  ex_mem;
    logic                     mem_stall_req;
    logic                     wb_stall_req;
    logic [`WB_REG_IDX_W-1:0] dbg_raddr;
    stall_vec_t               stall;
    commit_t                  commit;
    logic [`WB_XLEN-1:0]      dbg_rdata;

    step_t       steps [64];
    logic [63:0] pc_drv [64];
    int          n;
    int          limit;
    int          cycles;
    int          checks;
    int          errors;
    int          ntests;
    int          test_checks [16];
    int          test_errs [16];
    logic        file_ok;

    tb_clock u_clock (.clk_o(clk), .rst_n_o(rst_n));

    // a reset step from the cases file adds to the power-on reset
    assign arst_n = rst_n && !rst_req;

    wb_backend_top dut0 (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .ex_mem_i        (ex_mem),
        .mem_stall_req_i (mem_stall_req),
        .wb_stall_req_i  (wb_stall_req),
        .dbg_raddr_i     (dbg_raddr),
        .stall_o         (stall),
        .commit_o        (commit),
        .dbg_rdata_o     (dbg_rdata)
    );

    task automatic read_cases();
        int          fd;
        int          cnt;
        int          lno;
        string       line;
        logic [63:0] f [18];
        fd = $fopen("test/wb_cases.txt", "r");
        lno = 0;
        file_ok = (fd != 0);
        while (file_ok && n < 63 && $fgets(line, fd) != 0) begin
            lno++;
            if (line.len() > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
                if (cnt == 18) begin
                    steps[n] = {f[0][3:0], f[1][0], f[2][0], f[3][31:0], f[4][3:0],
                        f[5], f[6], f[7][4:0], f[8][0], f[9][0], f[10][0], f[11][4:0],
                        f[12][0], f[13][4:0], f[14][0], f[15], f[16][4:0], f[17]};
                    n++;
                end else begin
                    $display("cases file line %0d does not hold 18 fields", lno);
                    file_ok = 1'b0;
                end
            end
        end
        if (fd != 0) $fclose(fd);
        if (n == 0) file_ok = 1'b0;
        // idle step driven after the last line
        steps[n] = '0;
    endtask

    task automatic drive_step(input int i);
        logic [31:0] pc_hi;
        pc_hi = $urandom();
        pc_drv[i] = {pc_hi, steps[i].pc_lo};
        ex_mem.valid   <= steps[i].valid;
        ex_mem.pc      <= {pc_hi, steps[i].pc_lo};
        ex_mem.op      <= mem_op_e'(steps[i].op);
        ex_mem.addr    <= steps[i].addr;
        ex_mem.wdata   <= steps[i].wdata;
        ex_mem.rd_addr <= steps[i].rd;
        ex_mem.rd_en   <= steps[i].rd_en;
        mem_stall_req  <= steps[i].mreq;
        wb_stall_req   <= steps[i].wreq;
        dbg_raddr      <= steps[i].dbg;
        rst_req        <= steps[i].rst;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp, input logic [3:0] t);
        checks++;
        test_checks[t]++;
        if (got !== exp) begin
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
            test_errs[t]++;
        end
    endtask

    task automatic check_commit(input int j);
        logic [3:0] t;
        t = steps[j].test;
        check_value("commit_o.valid", 64'(commit.valid), 64'(steps[j].c_valid), t);
        if (steps[j].c_valid) begin
            check_value("commit_o.pc", commit.pc, pc_drv[j], t);
            check_value("commit_o.rd_addr", 64'(commit.rd_addr), 64'(steps[j].c_rd), t);
            check_value("commit_o.rd_en", 64'(commit.rd_en), 64'(steps[j].c_rd_en), t);
            // data only means something when a register is written
            if (steps[j].c_rd_en) begin
                check_value("commit_o.rd_data", commit.rd_data, steps[j].c_data, t);
            end
        end
    endtask

    task automatic report_test(input logic [3:0] t);
        ntests++;
        $display("test %0d: %0d checks, %0d errors, %s", t, test_checks[t], test_errs[t],
            (test_errs[t] == 0) ? "pass" : "fail");
    endtask

    // watchdog sized from the number of steps once the file is read
    initial begin
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(32'h7d58_0352));
        ex_mem = '0;
        mem_stall_req = 1'b0;
        wb_stall_req = 1'b0;
        dbg_raddr = '0;
        rst_req = 1'b0;
        read_cases();
        limit = 4 + n + 20;
        if (!file_ok) begin
            $display("could not load the steps from test/wb_cases.txt");
            errors++;
        end else begin
            @(posedge rst_n);
            // one extra cycle checks the commit of the last step
            for (int i = 0; i <= n; i++) begin
                @(posedge clk);
                drive_step(i);
                @(negedge clk);
                if (i < n) begin
                    check_value("stall_o", 64'(stall), 64'(steps[i].stall), steps[i].test);
                    check_value("dbg_rdata_o", dbg_rdata, steps[i].dbg_data, steps[i].test);
                end
                if (i > 0) begin
                    check_commit(i - 1);
                    if (i == n || steps[i].test != steps[i - 1].test) begin
                        report_test(steps[i - 1].test);
                    end
                end
            end
        end
        $display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/wb_cases.txt
# test rst valid pc_lo op addr wdata rd rd_en mem_req wb_req dbg_addr, then expected (all hex):
# commit_valid commit_rd commit_rd_en commit_data (next cycle), stall_o, dbg_rdata_o (this cycle)
# op: 0 none 1 lb 2 lh 3 lw 4 ld 5 lbu 6 lhu 7 lwu 8 sb 9 sh a sw b sd
1 0 1 1000 0 0 1122334455667788 01 1 0 0 01 1 01 1 1122334455667788 00 0
1 0 1 1004 0 0 ffffffffffffff80 00 1 0 0 01 1 00 1 ffffffffffffff80 00 0
1 0 1 1008 0 0 deadbeef 02 1 0 0 01 1 02 1 deadbeef 00 1122334455667788
1 0 0 100c 0 0 0 00 0 0 0 00 0 00 0 0 00 0
1 0 0 1010 0 0 0 00 0 0 0 02 0 00 0 0 00 deadbeef
2 0 1 2000 b 40 fedcba9876543210 05 1 0 0 00 1 05 0 0 00 0
2 0 1 2004 4 40 0 06 1 0 0 00 1 06 1 fedcba9876543210 00 0
2 0 1 2008 1 47 0 07 1 0 0 00 1 07 1 fffffffffffffffe 00 0
2 0 1 200c 5 45 0 08 1 0 0 06 1 08 1 ba 00 fedcba9876543210
2 0 1 2010 1 41 0 09 1 0 0 00 1 09 1 32 00 0
2 0 1 2014 2 46 0 0a 1 0 0 00 1 0a 1 fffffffffffffedc 00 0
2 0 1 2018 6 44 0 0b 1 0 0 00 1 0b 1 ba98 00 0
2 0 1 201c 2 43 0 0c 1 0 0 00 1 0c 1 7654 00 0
2 0 1 2020 3 44 0 0d 1 0 0 00 1 0d 1 fffffffffedcba98 00 0
2 0 1 2024 7 44 0 0e 1 0 0 00 1 0e 1 fedcba98 00 0
2 0 1 2028 3 40 0 0f 1 0 0 0d 1 0f 1 76543210 00 fffffffffedcba98
3 0 1 3000 b 80 1111111111111111 00 0 0 0 00 1 00 0 0 00 0
3 0 1 3004 a 84 55555555cafef00d 03 1 0 0 00 1 03 0 0 00 0
3 0 1 3008 8 83 ffffffffffffffaa 00 0 0 0 00 1 00 0 0 00 0
3 0 1 300c 9 81 bbcc 00 0 0 0 03 1 00 0 0 00 0
3 0 1 3010 4 80 0 10 1 0 0 03 1 10 1 cafef00daa11bbcc 00 0
3 0 1 3014 5 83 0 11 1 0 0 0f 1 11 1 aa 00 76543210
4 0 1 4000 0 0 444 04 1 1 0 10 0 00 0 0 0f cafef00daa11bbcc
4 0 1 4000 0 0 444 04 1 0 0 04 1 04 1 444 00 0
4 0 1 4004 b 80 9999999999999999 00 0 1 0 04 0 00 0 0 0f 0
4 0 1 4008 4 80 0 12 1 0 0 04 1 12 1 cafef00daa11bbcc 00 444
5 0 1 5000 0 0 5555 05 1 0 0 04 1 05 1 5555 00 444
5 0 1 5004 0 0 6666 06 1 0 1 05 0 00 0 0 1f 0
5 0 1 5004 0 0 6666 06 1 0 1 05 0 00 0 0 1f 5555
5 0 1 5004 0 0 6666 06 1 0 0 05 1 06 1 6666 00 5555
5 0 0 5008 0 0 0 00 0 0 0 06 0 00 0 0 00 fedcba9876543210
5 0 0 500c 0 0 0 00 0 0 0 06 0 00 0 0 00 6666
6 0 1 6000 0 0 7777 07 1 0 0 07 1 07 1 7777 00 fffffffffffffffe
6 0 0 6004 0 0 0 00 0 0 0 07 0 00 0 0 00 fffffffffffffffe
6 0 1 6008 0 0 8888 08 1 0 0 07 0 00 0 0 00 7777
6 1 0 600c 0 0 0 00 0 0 0 07 0 00 0 0 00 0
6 0 0 6010 0 0 0 00 0 0 0 08 0 00 0 0 00 0
6 0 1 6014 0 0 9999 09 1 0 0 09 1 09 1 9999 00 0
6 0 0 6018 0 0 0 00 0 0 0 09 0 00 0 0 00 0
6 0 0 601c 0 0 0 00 0 0 0 09 0 00 0 0 00 9999

// File: list.f
+incdir+common
common/wb_pkg.sv
mem_stage/mem_access.sv
src/stall_ctrl.sv
src/mem_wb_reg.sv
src/gpr_file.sv
src/wb_backend_top.sv
test/tb_clock.sv
test/wb_backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the back-end testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f list.f \
    --top-module wb_backend_tb -o sim_wb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_wb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
